// ==== common/pi_pkg.sv ====
/* shared memory port definitions */

package pi_pkg;

	// memory operation codes as issued by a master and seen by the slave
	typedef enum logic [1:0] {
		// nothing to do in this turn
		PI_NOOP = 2'd0,
		// write the selected bytes of the word
		PI_WROP = 2'd1,
		// read a whole word
		PI_RDOP = 2'd2,
		// write the selected bytes and return the word as it was before
		PI_RWOP = 2'd3
	} pi_op_e;

	// number of master ports sharing the memory
	localparam int PI_MASTERS = 3;

	// width of a master index, which is also the queue slot index
	localparam int PI_MIDX_BITS = 2;

	// queue pointers carry one wrap bit above the slot index
	localparam int PI_PTR_BITS = PI_MIDX_BITS + 1;

	// data word width and the byte lanes within it
	localparam int PI_ARCH_BITS = 16;
	localparam int PI_SEL_BITS = 2;
	localparam int PI_BYTE_BITS = PI_ARCH_BITS / PI_SEL_BITS;

	// word address as seen by the masters
	localparam int PI_ADDR_BITS = 15;

	// the memory only decodes the low address bits of its depth
	localparam int PI_MEM_WORDS = 256;
	localparam int PI_MEM_ABITS = $clog2(PI_MEM_WORDS);

endpackage

// ==== common/pi_slave_if.sv ====
/* queue to slave memory link */

`timescale 1ns/1ns

interface pi_slave_if;

	import pi_pkg::*;

	// operation presented by the queue, NOOP while the queue is empty
	pi_op_e op;

	// word address of the operation
	logic [PI_ADDR_BITS-1:0] addr;

	// write data and its byte lanes
	logic [PI_ARCH_BITS-1:0] wdata;
	logic [PI_SEL_BITS-1:0] sel;

	// word returned for a read or a read-write
	// valid at the next edge where rdy is high after the operation was taken
	logic [PI_ARCH_BITS-1:0] rdata;

	// the slave takes a non-NOOP op at every edge where this is high
	logic rdy;

	// arbiter queue side
	modport queue_mp (output op, output addr, output wdata, output sel,
		input rdata, input rdy);

	// memory side
	modport mem_mp (input op, input addr, input wdata, input sel,
		output rdata, output rdy);

endinterface

// ==== hw/pi_queue/pi_queue.sv ====
/* multi-master arbiter queue */

`timescale 1ns/1ns

module pi_queue (
	input logic m_clk_i,
	input logic rst_i,
	input pi_pkg::pi_op_e m_op_i [pi_pkg::PI_MASTERS],
	input logic [pi_pkg::PI_MASTERS-1:0][pi_pkg::PI_ADDR_BITS-1:0] m_addr_i,
	input logic [pi_pkg::PI_MASTERS-1:0][pi_pkg::PI_ARCH_BITS-1:0] m_data_i,
	input logic [pi_pkg::PI_MASTERS-1:0][pi_pkg::PI_SEL_BITS-1:0] m_sel_i,
	output logic [pi_pkg::PI_MASTERS-1:0][pi_pkg::PI_ARCH_BITS-1:0] m_data_o,
	output logic [pi_pkg::PI_MASTERS-1:0] m_rdy_o,
	pi_slave_if.queue_mp slv
);

	import pi_pkg::*;

	// every master owns exactly one slot, so the queue is PI_MASTERS deep
	pi_op_e slot_op [PI_MASTERS];
	logic [PI_ADDR_BITS-1:0] slot_addr [PI_MASTERS];
	logic [PI_ARCH_BITS-1:0] slot_data [PI_MASTERS];
	logic [PI_SEL_BITS-1:0] slot_sel [PI_MASTERS];

	// write pointer follows the master rotation, read pointer the slave
	logic [PI_PTR_BITS-1:0] wr_ptr;
	logic [PI_PTR_BITS-1:0] rd_ptr;
	logic [PI_PTR_BITS-1:0] wr_ptr_n;
	logic [PI_PTR_BITS-1:0] rd_ptr_n;
	logic [PI_MIDX_BITS-1:0] wr_idx;
	logic [PI_MIDX_BITS-1:0] rd_idx;

	// slot of the last read or read-write taken by the slave
	// ret_vld stays high until its word comes back
	logic ret_vld;
	logic [PI_MIDX_BITS-1:0] ret_idx;
	logic ret_vld_n;
	logic [PI_MIDX_BITS-1:0] ret_idx_n;

	logic q_empty;
	logic wr_take;
	logic rd_adv;
	logic [PI_MASTERS-1:0] rdy_n;

	// step a pointer to the next slot, toggling the wrap bit after the last master
	function automatic logic [PI_PTR_BITS-1:0] ptr_inc(input logic [PI_PTR_BITS-1:0] p);
		if (p[PI_MIDX_BITS-1:0] == PI_MIDX_BITS'(PI_MASTERS - 1)) begin
			return {~p[PI_PTR_BITS-1], {PI_MIDX_BITS{1'b0}}};
		end
		return p + 1'b1;
	endfunction

	// number of queued slots between the two pointers
	function automatic logic [PI_PTR_BITS-1:0] q_fill(input logic [PI_PTR_BITS-1:0] wr,
		input logic [PI_PTR_BITS-1:0] rd);
		logic [PI_PTR_BITS-1:0] wi;
		logic [PI_PTR_BITS-1:0] ri;
		wi = {1'b0, wr[PI_MIDX_BITS-1:0]};
		ri = {1'b0, rd[PI_MIDX_BITS-1:0]};
		if (wr[PI_PTR_BITS-1] == rd[PI_PTR_BITS-1]) begin
			return wi - ri;
		end
		return wi + PI_PTR_BITS'(PI_MASTERS) - ri;
	endfunction

	// master readiness for a given queue state
	// only the master at the write slot may go, and not while the queue is full
	// when near full the free slot is the one the slave just took, and if that
	// was a read its word has not landed in m_data_o yet
	function automatic logic [PI_MASTERS-1:0] rdy_calc(input logic [PI_PTR_BITS-1:0] wr,
		input logic [PI_PTR_BITS-1:0] rd, input logic pend_vld,
		input logic [PI_MIDX_BITS-1:0] pend_idx);
		logic [PI_PTR_BITS-1:0] fill;
		logic full;
		logic near_full;
		logic slot_pend;
		logic [PI_MASTERS-1:0] rdy;
		fill = q_fill(wr, rd);
		full = (fill == PI_PTR_BITS'(PI_MASTERS));
		near_full = (fill == PI_PTR_BITS'(PI_MASTERS - 1));
		slot_pend = pend_vld && (pend_idx == wr[PI_MIDX_BITS-1:0]);
		for (int i = 0; i < PI_MASTERS; i++) begin
			rdy[i] = (wr[PI_MIDX_BITS-1:0] == PI_MIDX_BITS'(i)) && !full &&
				!(near_full && slot_pend);
		end
		return rdy;
	endfunction

	assign wr_idx = wr_ptr[PI_MIDX_BITS-1:0];
	assign rd_idx = rd_ptr[PI_MIDX_BITS-1:0];
	assign q_empty = (wr_ptr == rd_ptr);

	// the master that holds the turn always hands over its inputs, even a NOOP
	assign wr_take = |m_rdy_o;

	// the head slot only leaves when the slave takes it, so back-pressure stalls it
	assign rd_adv = !q_empty && slv.rdy;

	// the slave sees the head slot one cycle after the master handed it in
	assign slv.op = q_empty ? PI_NOOP : slot_op[rd_idx];
	assign slv.addr = slot_addr[rd_idx];
	assign slv.wdata = slot_data[rd_idx];
	assign slv.sel = slot_sel[rd_idx];

	always_comb begin
		wr_ptr_n = wr_take ? ptr_inc(wr_ptr) : wr_ptr;
		rd_ptr_n = rd_adv ? ptr_inc(rd_ptr) : rd_ptr;
		// the return tracker moves only on slave ready edges
		// a taken read or read-write has opcode bit 1 set
		ret_vld_n = ret_vld;
		ret_idx_n = ret_idx;
		if (slv.rdy) begin
			ret_vld_n = rd_adv && slot_op[rd_idx][1];
			if (rd_adv) begin
				ret_idx_n = rd_idx;
			end
		end
		// readiness is registered from the next state so it is low in reset
		rdy_n = rdy_calc(wr_ptr_n, rd_ptr_n, ret_vld_n, ret_idx_n);
	end

	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			ret_vld <= 1'b0;
			ret_idx <= '0;
			m_rdy_o <= '0;
		end else begin
			wr_ptr <= wr_ptr_n;
			rd_ptr <= rd_ptr_n;
			ret_vld <= ret_vld_n;
			ret_idx <= ret_idx_n;
			m_rdy_o <= rdy_n;
		end
	end

	// load the slot of the master that holds the turn
	always_ff @(posedge m_clk_i) begin
		if (wr_take) begin
			slot_op[wr_idx] <= m_op_i[wr_idx];
			slot_addr[wr_idx] <= m_addr_i[wr_idx];
			slot_data[wr_idx] <= m_data_i[wr_idx];
			slot_sel[wr_idx] <= m_sel_i[wr_idx];
		end
	end

	// route the returned word to the master whose slot asked for it
	always_ff @(posedge m_clk_i) begin
		if (slv.rdy && ret_vld) begin
			m_data_o[ret_idx] <= slv.rdata;
		end
	end

	// only one master may hold the turn in a cycle
	a_rdy_onehot: assert property (@(posedge m_clk_i) disable iff (rst_i)
		$onehot0(m_rdy_o));

	// the rotation can never run a full queue of work ahead of the slave
	a_ptr_span: assert property (@(posedge m_clk_i) disable iff (rst_i)
		q_fill(wr_ptr, rd_ptr) <= PI_PTR_BITS'(PI_MASTERS));

endmodule

// ==== hw/pi_mem/pi_mem.sv ====
/* byte-select slave memory */

`timescale 1ns/1ns

module pi_mem (
	input logic m_clk_i,
	input logic rst_i,
	pi_slave_if.mem_mp slv
);

	import pi_pkg::*;

	logic [PI_ARCH_BITS-1:0] mem_q [PI_MEM_WORDS];

	// high in the second cycle of a read-write, which is when the new bytes go in
	logic rw_phase;

	// read-write operands held over into the second phase
	logic [PI_MEM_ABITS-1:0] rw_addr;
	logic [PI_ARCH_BITS-1:0] rw_wdata;
	logic [PI_SEL_BITS-1:0] rw_sel;

	logic acc;
	logic acc_rd;
	logic acc_rw;
	logic [PI_MEM_ABITS-1:0] acc_addr;

	// one write port shared by plain writes and the read-write second phase
	logic wr_en;
	logic [PI_MEM_ABITS-1:0] wr_addr;
	logic [PI_ARCH_BITS-1:0] wr_data;
	logic [PI_SEL_BITS-1:0] wr_sel;

	// ready only drops while the read-write finishes its write
	assign slv.rdy = !rw_phase;

	// an operation is taken at every ready edge that carries a real opcode
	assign acc = slv.rdy && (slv.op != PI_NOOP);
	assign acc_rw = acc && (slv.op == PI_RWOP);
	assign acc_rd = acc && (slv.op == PI_RDOP || slv.op == PI_RWOP);

	// the upper address bits fall outside the memory and are not decoded
	assign acc_addr = slv.addr[PI_MEM_ABITS-1:0];

	always_comb begin
		if (rw_phase) begin
			wr_en = 1'b1;
			wr_addr = rw_addr;
			wr_data = rw_wdata;
			wr_sel = rw_sel;
		end else begin
			wr_en = acc && (slv.op == PI_WROP);
			wr_addr = acc_addr;
			wr_data = slv.wdata;
			wr_sel = slv.sel;
		end
	end

	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			rw_phase <= 1'b0;
		end else begin
			rw_phase <= acc_rw;
		end
	end

	// the old word is captured before the read-write touches it
	// rdata then holds until the next read is taken
	always_ff @(posedge m_clk_i) begin
		if (acc_rd) begin
			slv.rdata <= mem_q[acc_addr];
		end
		if (acc_rw) begin
			rw_addr <= acc_addr;
			rw_wdata <= slv.wdata;
			rw_sel <= slv.sel;
		end
	end

	// bytes whose select is low keep their old value
	always_ff @(posedge m_clk_i) begin
		if (wr_en) begin
			for (int b = 0; b < PI_SEL_BITS; b++) begin
				if (wr_sel[b]) begin
					mem_q[wr_addr][b*PI_BYTE_BITS +: PI_BYTE_BITS] <=
						wr_data[b*PI_BYTE_BITS +: PI_BYTE_BITS];
				end
			end
		end
	end

	// a stall lasts a single cycle, so the queue never waits longer than that
	a_rdy_stall: assert property (@(posedge m_clk_i) disable iff (rst_i)
		!slv.rdy |=> slv.rdy);

endmodule

// ==== hw/pi_top.sv ====
/* shared memory port top */

`timescale 1ns/1ns

module pi_top (
	input logic m_clk_i,
	input logic rst_i,
	input logic [2*pi_pkg::PI_MASTERS-1:0] m_op_i,
	input logic [pi_pkg::PI_MASTERS*pi_pkg::PI_ADDR_BITS-1:0] m_addr_i,
	input logic [pi_pkg::PI_MASTERS*pi_pkg::PI_ARCH_BITS-1:0] m_data_i,
	input logic [pi_pkg::PI_MASTERS*pi_pkg::PI_SEL_BITS-1:0] m_sel_i,
	output logic [pi_pkg::PI_MASTERS*pi_pkg::PI_ARCH_BITS-1:0] m_data_o,
	output logic [pi_pkg::PI_MASTERS-1:0] m_rdy_o
);

	import pi_pkg::*;

	// per-master views of the flat ports, master 0 in the low bits
	pi_op_e m_op [PI_MASTERS];
	logic [PI_MASTERS-1:0][PI_ADDR_BITS-1:0] m_addr;
	logic [PI_MASTERS-1:0][PI_ARCH_BITS-1:0] m_wdata;
	logic [PI_MASTERS-1:0][PI_SEL_BITS-1:0] m_sel;
	logic [PI_MASTERS-1:0][PI_ARCH_BITS-1:0] m_rdata;

	for (genvar g = 0; g < PI_MASTERS; g++) begin : g_master
		assign m_op[g] = pi_op_e'(m_op_i[2*g +: 2]);
		assign m_addr[g] = m_addr_i[g*PI_ADDR_BITS +: PI_ADDR_BITS];
		assign m_wdata[g] = m_data_i[g*PI_ARCH_BITS +: PI_ARCH_BITS];
		assign m_sel[g] = m_sel_i[g*PI_SEL_BITS +: PI_SEL_BITS];
		assign m_data_o[g*PI_ARCH_BITS +: PI_ARCH_BITS] = m_rdata[g];
	end

	// single link from the queue head to the memory
	pi_slave_if slv_if ();

	pi_queue pi_queue_i (
		.m_clk_i (m_clk_i),
		.rst_i (rst_i),
		.m_op_i (m_op),
		.m_addr_i (m_addr),
		.m_data_i (m_wdata),
		.m_sel_i (m_sel),
		.m_data_o (m_rdata),
		.m_rdy_o (m_rdy_o),
		.slv (slv_if.queue_mp)
	);

	pi_mem pi_mem_i (
		.m_clk_i (m_clk_i),
		.rst_i (rst_i),
		.slv (slv_if.mem_mp)
	);

endmodule

// ==== test/tb_pi_tasks.svh ====
/* testbench reference model and stimulus */

`ifndef TB_PI_TASKS_SVH
`define TB_PI_TASKS_SVH

	// reference memory, updated in the order the turns are given
	logic [PI_ARCH_BITS-1:0] ref_mem [PI_MEM_WORDS];

	// expected m_data_o per master, valid once that master has read once
	logic [PI_ARCH_BITS-1:0] exp_data [PI_MASTERS];
	logic [PI_MASTERS-1:0] exp_vld = '0;

	// next operation each master presents until its turn comes
	pi_op_e p_op [PI_MASTERS];
	logic [PI_ADDR_BITS-1:0] p_addr [PI_MASTERS];
	logic [PI_ARCH_BITS-1:0] p_data [PI_MASTERS];
	logic [PI_SEL_BITS-1:0] p_sel [PI_MASTERS];

	// per-test generator state
	int mode = 1;
	int fill_next = 0;
	logic [PI_MASTERS-1:0] wr_phase = '0;
	logic [PI_ADDR_BITS-1:0] last_addr [PI_MASTERS];
	logic [PI_ADDR_BITS-1:0] sw_addr = '0;
	int sw_cnt = 0;
	logic [31:0] lfsr = 32'd69169;

	// galois LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb) begin
			s = s ^ 32'h8020_0003;
		end
		return s;
	endfunction

	// one LFSR step for every bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// bytes with a low select keep the old value
	function automatic logic [PI_ARCH_BITS-1:0] merge_word(input logic [PI_ARCH_BITS-1:0] old_w,
		input logic [PI_ARCH_BITS-1:0] new_w, input logic [PI_SEL_BITS-1:0] sel);
		logic [PI_ARCH_BITS-1:0] w;
		w = old_w;
		for (int b = 0; b < PI_SEL_BITS; b++) begin
			if (sel[b]) begin
				w[b*PI_BYTE_BITS +: PI_BYTE_BITS] = new_w[b*PI_BYTE_BITS +: PI_BYTE_BITS];
			end
		end
		return w;
	endfunction

	// fill word mixes every address bit into both bytes
	function automatic logic [PI_ARCH_BITS-1:0] fill_word(input int a);
		return PI_ARCH_BITS'(a * 16'h9e37) ^ {8'(a), ~8'(a)};
	endfunction

	// pick the next operation of master i for the running test
	task automatic gen_op(input int i);
		logic [31:0] r;
		p_op[i] = PI_NOOP;
		case (mode)
			1: begin
				if (fill_next < PI_MEM_WORDS) begin
					p_op[i] = PI_WROP;
					p_addr[i] = PI_ADDR_BITS'(fill_next);
					p_data[i] = fill_word(fill_next);
					p_sel[i] = '1;
					fill_next++;
				end
			end
			2: begin
				p_op[i] = PI_RDOP;
				take_bits(PI_ADDR_BITS, r);
				p_addr[i] = r[PI_ADDR_BITS-1:0];
			end
			3: begin
				// a write under random lanes, then a read of the same word
				if (!wr_phase[i]) begin
					p_op[i] = PI_WROP;
					take_bits(PI_ADDR_BITS, r);
					last_addr[i] = r[PI_ADDR_BITS-1:0];
					take_bits(PI_ARCH_BITS, r);
					p_data[i] = r[PI_ARCH_BITS-1:0];
					take_bits(PI_SEL_BITS, r);
					p_sel[i] = r[PI_SEL_BITS-1:0];
				end else begin
					p_op[i] = PI_RDOP;
				end
				p_addr[i] = last_addr[i];
				wr_phase[i] = !wr_phase[i];
			end
			4: begin
				// master 0 swaps a shared word, the others read it back
				if (i == 0) begin
					if (sw_cnt % 3 == 0) begin
						take_bits(PI_ADDR_BITS, r);
						sw_addr = r[PI_ADDR_BITS-1:0];
					end
					sw_cnt++;
					p_op[i] = PI_RWOP;
					take_bits(PI_ARCH_BITS, r);
					p_data[i] = r[PI_ARCH_BITS-1:0];
					take_bits(PI_SEL_BITS, r);
					p_sel[i] = r[PI_SEL_BITS-1:0];
				end else begin
					p_op[i] = PI_RDOP;
				end
				p_addr[i] = sw_addr;
			end
			5: begin
				// eight words only, with random high bits the memory ignores
				take_bits(2, r);
				p_op[i] = pi_op_e'(r[1:0]);
				take_bits(10, r);
				p_addr[i] = {r[9:3], 5'd0, r[2:0]};
				take_bits(PI_ARCH_BITS, r);
				p_data[i] = r[PI_ARCH_BITS-1:0];
				take_bits(PI_SEL_BITS, r);
				p_sel[i] = r[PI_SEL_BITS-1:0];
			end
			default: p_op[i] = PI_NOOP;
		endcase
	endtask

`endif

// ==== test/tb_pi_top.sv ====
/* shared memory port testbench */

`timescale 1ns/1ns

module tb_pi_top;

	import pi_pkg::*;

	// test lengths in rounds, one turn per master in each round
	localparam int LEN_FILL = 86;
	localparam int LEN_ROT = 20;
	localparam int LEN_WRRD = 30;
	localparam int LEN_SWAP = 30;
	localparam int LEN_CONC = 60;
	localparam int LEN_DRAIN = 2;
	localparam int LEN_SUM = LEN_FILL + LEN_ROT + LEN_WRRD + LEN_SWAP + LEN_CONC + LEN_DRAIN;
	localparam int WDOG_CYCLES = LEN_SUM * PI_MASTERS * 4 + 500;

	logic m_clk_i = 1'b0;
	logic rst_i;
	logic [2*PI_MASTERS-1:0] m_op_i = '0;
	logic [PI_MASTERS*PI_ADDR_BITS-1:0] m_addr_i = '0;
	logic [PI_MASTERS*PI_ARCH_BITS-1:0] m_data_i = '0;
	logic [PI_MASTERS*PI_SEL_BITS-1:0] m_sel_i = '0;
	logic [PI_MASTERS*PI_ARCH_BITS-1:0] m_data_o;
	logic [PI_MASTERS-1:0] m_rdy_o;

	// readies seen in the middle of the cycle, acted on at the next edge
	logic [PI_MASTERS-1:0] rdy_q = '0;
	logic primed = 1'b0;
	int next_turn = 0;
	int gap_cnt = 0;
	int turn_cnt = 0;
	int chk_cnt = 0;
	int err_cnt = 0;
	int test_cnt = 0;

	`include "tb_pi_tasks.svh"

	pi_top pi_top_i (
		.m_clk_i (m_clk_i),
		.rst_i (rst_i),
		.m_op_i (m_op_i),
		.m_addr_i (m_addr_i),
		.m_data_i (m_data_i),
		.m_sel_i (m_sel_i),
		.m_data_o (m_data_o),
		.m_rdy_o (m_rdy_o)
	);

	initial begin
		forever #10 m_clk_i = ~m_clk_i;
	end

	// put the pending operation of master i on its ports
	task automatic drive_ports(input int i);
		m_op_i[2*i +: 2] <= p_op[i];
		m_addr_i[i*PI_ADDR_BITS +: PI_ADDR_BITS] <= p_addr[i];
		m_data_i[i*PI_ARCH_BITS +: PI_ARCH_BITS] <= p_data[i];
		m_sel_i[i*PI_SEL_BITS +: PI_SEL_BITS] <= p_sel[i];
	endtask

	// the DUT took the pending op of master i at this edge
	task automatic consume(input int i);
		int a;
		a = int'(p_addr[i][PI_MEM_ABITS-1:0]);
		// the assertion checks the previous result at this same edge
		if (exp_vld[i]) begin
			chk_cnt++;
		end
		case (p_op[i])
			PI_WROP: ref_mem[a] = merge_word(ref_mem[a], p_data[i], p_sel[i]);
			PI_RDOP: begin
				exp_data[i] <= ref_mem[a];
				exp_vld[i] <= 1'b1;
			end
			PI_RWOP: begin
				exp_data[i] <= ref_mem[a];
				exp_vld[i] <= 1'b1;
				ref_mem[a] = merge_word(ref_mem[a], p_data[i], p_sel[i]);
			end
			default: ;
		endcase
		turn_cnt++;
		next_turn <= (i + 1) % PI_MASTERS;
		gen_op(i);
		drive_ports(i);
	endtask

	always @(negedge m_clk_i) begin
		rdy_q <= rst_i ? '0 : m_rdy_o;
	end

	always @(posedge m_clk_i) begin
		if (rst_i && !primed) begin
			primed <= 1'b1;
			for (int i = 0; i < PI_MASTERS; i++) begin
				gen_op(i);
				drive_ports(i);
			end
		end
		for (int i = 0; i < PI_MASTERS; i++) begin
			if (rdy_q[i]) begin
				consume(i);
			end
		end
		gap_cnt <= (rst_i || |rdy_q) ? 0 : gap_cnt + 1;
	end

	// readies stay low through reset
	a_rst_rdy: assert property (@(posedge m_clk_i) rst_i |=> m_rdy_o == '0)
	else begin
		err_cnt++;
		$display("** Error at %0t: m_rdy_o expected 0 actual %b", $time, $sampled(m_rdy_o));
	end

	// master 0 gets the first turn after reset
	a_first_rdy: assert property (@(posedge m_clk_i) rst_i ##1 !rst_i |=> m_rdy_o == 3'b001)
	else begin
		err_cnt++;
		$display("** Error at %0t: m_rdy_o expected 001 actual %b", $time, $sampled(m_rdy_o));
	end

	a_onehot: assert property (@(posedge m_clk_i) disable iff (rst_i) $onehot0(m_rdy_o))
	else begin
		err_cnt++;
		$display("more than one master was ready at %0t", $time);
	end

	// turns rotate through every master in index order
	a_order: assert property (@(posedge m_clk_i) disable iff (rst_i)
		|m_rdy_o |-> m_rdy_o[next_turn])
	else begin
		err_cnt++;
		$display("turn went out of order at %0t, master %0d was due", $time, next_turn);
	end

	// no long stretch without any master holding a turn
	a_gap: assert property (@(posedge m_clk_i) disable iff (rst_i) gap_cnt < 8)
	else begin
		err_cnt++;
		$display("no master was ready for %0d cycles at %0t", gap_cnt, $time);
	end

	for (genvar g = 0; g < PI_MASTERS; g++) begin : g_chk
		// the latest read result is on m_data_o at the master's next turn
		a_data: assert property (@(posedge m_clk_i) disable iff (rst_i)
			m_rdy_o[g] && exp_vld[g] |->
			m_data_o[g*PI_ARCH_BITS +: PI_ARCH_BITS] == exp_data[g])
		else begin
			err_cnt++;
			$display("** Error at %0t: m_data_o[%0d] expected %h actual %h", $time, g,
				$sampled(exp_data[g]), $sampled(m_data_o[g*PI_ARCH_BITS +: PI_ARCH_BITS]));
		end
	end

	task automatic run_test(input string name, input int m, input int rounds);
		int target;
		int err_start;
		err_start = err_cnt;
		mode = m;
		target = turn_cnt + rounds * PI_MASTERS;
		// turns are counted at the rising edge, so look between edges
		while (turn_cnt < target) begin
			@(negedge m_clk_i);
		end
		test_cnt++;
		$display("test %0d %s finished, %0d turns, %0d errors", test_cnt, name,
			rounds * PI_MASTERS, err_cnt - err_start);
	endtask

	initial begin
		rst_i <= 1'b1;
		repeat (2) @(posedge m_clk_i);
		rst_i <= 1'b0;
		run_test("reset and fill", 1, LEN_FILL);
		run_test("rotation", 2, LEN_ROT);
		run_test("write then read", 3, LEN_WRRD);
		run_test("read-write swap", 4, LEN_SWAP);
		run_test("concurrency", 5, LEN_CONC);
		// idle rounds let the last results reach their checks
		mode = 0;
		repeat (LEN_DRAIN * PI_MASTERS * 4) @(negedge m_clk_i);
		$display("%0d tests, %0d data checks, %0d errors", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog sized from the summed test lengths
	initial begin
		repeat (WDOG_CYCLES) @(posedge m_clk_i);
		$display("watchdog expired after %0d cycles with %0d turns done", WDOG_CYCLES, turn_cnt);
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+test
common/pi_pkg.sv
common/pi_slave_if.sv
hw/pi_queue/pi_queue.sv
hw/pi_mem/pi_mem.sv
hw/pi_top.sv
test/tb_pi_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
TOP ?= tb_pi_top
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir

.PHONY: run build lint clean

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
